// ==== hdl/cpu_defines_pkg.sv ====
/*
 * Execute-stage vocabulary shared across the pipeline: the data word width
 * and the ALU operation codes that reach the multiply/divide path.
 * Referenced by scoped name from the RTL and the testbench.
 */
package cpu_defines_pkg;

   // datapath width
   localparam int word_width   = 32;
   localparam int alu_op_width = 5;

   // execute operation codes seen by the mul/div block
   localparam logic [alu_op_width-1:0] op_nop   = 5'd0;
   localparam logic [alu_op_width-1:0] op_mult  = 5'd1;  // signed 32x32
   localparam logic [alu_op_width-1:0] op_multu = 5'd2;  // unsigned 32x32
   localparam logic [alu_op_width-1:0] op_div   = 5'd3;  // signed, iterative
   localparam logic [alu_op_width-1:0] op_divu  = 5'd4;  // unsigned, iterative
   localparam logic [alu_op_width-1:0] op_mthi  = 5'd5;  // hi <= rs
   localparam logic [alu_op_width-1:0] op_mtlo  = 5'd6;  // lo <= rs
   localparam logic [alu_op_width-1:0] op_mfhi  = 5'd7;  // rd <= hi
   localparam logic [alu_op_width-1:0] op_mflo  = 5'd8;  // rd <= lo

   /*
    * Codes 9..31 belong to the ALU proper and never reach this block
    * with any effect. The mul/div unit treats them like op_nop.
    */

   // the arithmetic codes are the four multiply and divide ops
   // and the move codes only touch the HI/LO pair

endpackage

// ==== hdl/muldiv_pkg.sv ====
/*
 * Internals of the multiply/divide block: divider iteration count, the
 * state encoding shared by the divider and its controller, and the 64-bit
 * result word that is seen either whole or as its HI/LO halves.
 */
package muldiv_pkg;

   // one quotient bit per iteration
   localparam int div_iterations  = 32;
   localparam int div_count_width = 6;

   // last count value spent in busy; the final iteration runs in done
   localparam logic [div_count_width-1:0] div_last_busy =
      div_count_width'(div_iterations - 2);

   // state encoding
   localparam int state_width = 2;
   localparam logic [state_width-1:0] div_state_idle = 2'd0;
   localparam logic [state_width-1:0] div_state_busy = 2'd1;
   localparam logic [state_width-1:0] div_state_done = 2'd2;

   /*
    * The product is formed as one 64-bit value, while the divider and the
    * HI/LO writes deal in halves: quotient in lo, remainder in hi.
    */
   typedef union packed {
      logic [2*cpu_defines_pkg::word_width-1:0] whole;
      struct packed {
         logic [cpu_defines_pkg::word_width-1:0] hi;
         logic [cpu_defines_pkg::word_width-1:0] lo;
      } half;
   } muldiv_result_u;

endpackage

// ==== hdl/serial_divider.sv ====
/*
 * Restoring shift-subtract divider for DIV and DIVU. A start pulse latches
 * the operand magnitudes; one quotient bit is produced per cycle and done
 * pulses after 32 cycles with quotient in lo and remainder in hi.
 */
`timescale 1ns/1ns

module serial_divider (
   input  logic                                     clk,
   input  logic                                     rst,
   input  logic                                     div_start,
   input  logic                                     div_abort,
   input  logic                                     div_signed,
   input  logic [cpu_defines_pkg::word_width-1:0]   dividend,
   input  logic [cpu_defines_pkg::word_width-1:0]   divisor,
   output logic                                     div_done,
   output muldiv_pkg::muldiv_result_u               div_result
);

   logic [muldiv_pkg::state_width-1:0]      state_q;
   logic [muldiv_pkg::div_count_width-1:0]  count_q;
   logic [cpu_defines_pkg::word_width-1:0]  rem_q;     // partial remainder
   logic [cpu_defines_pkg::word_width-1:0]  quo_q;     // dividend bits out, quotient bits in
   logic [cpu_defines_pkg::word_width-1:0]  dvs_q;     // divisor magnitude
   logic                                    q_neg_q;
   logic                                    r_neg_q;

   logic [cpu_defines_pkg::word_width-1:0]  dvd_mag;
   logic [cpu_defines_pkg::word_width-1:0]  dvs_mag;
   logic [cpu_defines_pkg::word_width+1:0]  trial;     // two spare bits for the borrow
   logic [cpu_defines_pkg::word_width-1:0]  rem_next;
   logic [cpu_defines_pkg::word_width-1:0]  quo_next;

   // operand magnitudes, only negated for signed ops
   always_comb begin
      dvd_mag = (div_signed && dividend[cpu_defines_pkg::word_width-1]) ? -dividend : dividend;
      dvs_mag = (div_signed && divisor[cpu_defines_pkg::word_width-1]) ? -divisor : divisor;
   end

   // one restoring step
   always_comb begin
      trial = {1'b0, rem_q, quo_q[cpu_defines_pkg::word_width-1]} - {2'b00, dvs_q};
      if (trial[cpu_defines_pkg::word_width+1]) begin
         // borrow, keep the shifted remainder
         rem_next = {rem_q[cpu_defines_pkg::word_width-2:0],
                     quo_q[cpu_defines_pkg::word_width-1]};
      end else begin
         rem_next = trial[cpu_defines_pkg::word_width-1:0];
      end
      quo_next = {quo_q[cpu_defines_pkg::word_width-2:0], ~trial[cpu_defines_pkg::word_width+1]};
   end

   // last step is taken combinationally in the done cycle
   always_comb begin
      div_result.half.lo = q_neg_q ? -quo_next : quo_next;
      div_result.half.hi = r_neg_q ? -rem_next : rem_next;  // follows dividend sign
   end

   assign div_done = (state_q == muldiv_pkg::div_state_done);

   always_ff @(posedge clk or negedge rst) begin
      if (!rst) begin
         state_q <= muldiv_pkg::div_state_idle;
         count_q <= '0;
         rem_q   <= '0;
         quo_q   <= '0;
         dvs_q   <= '0;
         q_neg_q <= 1'b0;
         r_neg_q <= 1'b0;
      end else begin
         case (state_q)
            muldiv_pkg::div_state_idle: begin
               if (div_start) begin
                  rem_q   <= '0;
                  quo_q   <= dvd_mag;
                  dvs_q   <= dvs_mag;
                  q_neg_q <= div_signed &
                             (dividend[cpu_defines_pkg::word_width-1] ^
                              divisor[cpu_defines_pkg::word_width-1]);
                  r_neg_q <= div_signed & dividend[cpu_defines_pkg::word_width-1];
                  count_q <= '0;
                  state_q <= muldiv_pkg::div_state_busy;
               end
            end
            muldiv_pkg::div_state_busy: begin
               if (div_abort) begin
                  state_q <= muldiv_pkg::div_state_idle;  // flushed mid-divide
               end else begin
                  rem_q   <= rem_next;
                  quo_q   <= quo_next;
                  count_q <= count_q + 1'b1;
                  if (count_q == muldiv_pkg::div_last_busy) begin
                     state_q <= muldiv_pkg::div_state_done;
                  end
               end
            end
            muldiv_pkg::div_state_done: begin
               state_q <= muldiv_pkg::div_state_idle;  // result taken this cycle
            end
            default: begin
               state_q <= muldiv_pkg::div_state_idle;
            end
         endcase
      end
   end

   // the controller must not restart a divide that is still running
   a_start_when_idle: assert property (
      @(posedge clk) disable iff (!rst)
      div_start |-> (state_q == muldiv_pkg::div_state_idle)
   ) else $error("divider started while busy");

   // done lands exactly div_iterations cycles after start unless aborted
   a_done_latency: assert property (
      @(posedge clk) disable iff (!rst)
      div_start ##1 (!div_abort) [*(muldiv_pkg::div_iterations - 1)] |-> ##1 div_done
   ) else $error("divider done pulse out of place");

endmodule

// ==== hdl/muldiv_unit.sv ====
/*
 * Multiply/divide control for the execute stage. Forms the single-cycle
 * product, sequences the serial divider while holding stall, and issues
 * the HI/LO write requests for MULT, DIV, MTHI and MTLO. Flush kills all.
 */
`timescale 1ns/1ns

module muldiv_unit (
   input  logic                                       clk,
   input  logic                                       rst,
   input  logic [cpu_defines_pkg::alu_op_width-1:0]   alu_op,
   input  logic [cpu_defines_pkg::word_width-1:0]     operand_a,
   input  logic [cpu_defines_pkg::word_width-1:0]     operand_b,
   input  logic                                       flush,
   input  logic                                       div_done,
   input  muldiv_pkg::muldiv_result_u                 div_result,
   output logic                                       div_start,
   output logic                                       div_abort,
   output logic                                       div_signed,
   output logic [cpu_defines_pkg::word_width-1:0]     dividend,
   output logic [cpu_defines_pkg::word_width-1:0]     divisor,
   output logic                                       stall,
   output logic                                       hi_we,
   output logic                                       lo_we,
   output logic [cpu_defines_pkg::word_width-1:0]     hi_wdata,
   output logic [cpu_defines_pkg::word_width-1:0]     lo_wdata
);

   logic                                    is_div_op;
   logic [cpu_defines_pkg::word_width:0]    a_ext;      // 33-bit, sign or zero extended
   logic [cpu_defines_pkg::word_width:0]    b_ext;
   logic [2*cpu_defines_pkg::word_width+1:0] prod_full;
   muldiv_pkg::muldiv_result_u              product;
   logic [muldiv_pkg::state_width-1:0]      state_q;
   logic [muldiv_pkg::state_width-1:0]      state_next;

   assign is_div_op = (alu_op == cpu_defines_pkg::op_div) ||
                      (alu_op == cpu_defines_pkg::op_divu);

   // one signed multiplier covers both flavours
   always_comb begin
      if (alu_op == cpu_defines_pkg::op_mult) begin
         a_ext = {operand_a[cpu_defines_pkg::word_width-1], operand_a};
         b_ext = {operand_b[cpu_defines_pkg::word_width-1], operand_b};
      end else begin
         a_ext = {1'b0, operand_a};
         b_ext = {1'b0, operand_b};
      end
      prod_full     = $signed(a_ext) * $signed(b_ext);
      product.whole = prod_full[2*cpu_defines_pkg::word_width-1:0];
   end

   // divider operands come straight from the held pipeline inputs
   assign div_signed = (alu_op == cpu_defines_pkg::op_div);
   assign dividend   = operand_a;
   assign divisor    = operand_b;

   // divide controller
   always_comb begin
      state_next = state_q;
      div_start  = 1'b0;
      case (state_q)
         muldiv_pkg::div_state_idle: begin
            if (is_div_op && !flush) begin
               div_start  = 1'b1;
               state_next = muldiv_pkg::div_state_busy;
            end
         end
         muldiv_pkg::div_state_busy: begin
            if (flush || div_done) begin
               state_next = muldiv_pkg::div_state_idle;
            end
         end
         default: state_next = muldiv_pkg::div_state_idle;
      endcase
   end

   always_ff @(posedge clk or negedge rst) begin
      if (!rst) begin
         state_q <= muldiv_pkg::div_state_idle;
      end else begin
         state_q <= state_next;
      end
   end

   assign div_abort = flush && (state_q == muldiv_pkg::div_state_busy);

   // hold the pipeline from the start cycle until the done cycle
   assign stall = !flush &&
                  (((state_q == muldiv_pkg::div_state_idle) && is_div_op) ||
                   ((state_q == muldiv_pkg::div_state_busy) && !div_done));

   // HI/LO write request
   always_comb begin
      hi_we    = 1'b0;
      lo_we    = 1'b0;
      hi_wdata = operand_a;  // MTHI/MTLO data
      lo_wdata = operand_a;
      if ((state_q == muldiv_pkg::div_state_busy) && div_done) begin
         hi_we    = 1'b1;
         lo_we    = 1'b1;
         hi_wdata = div_result.half.hi;  // remainder
         lo_wdata = div_result.half.lo;  // quotient
      end else begin
         case (alu_op)
            cpu_defines_pkg::op_mult, cpu_defines_pkg::op_multu: begin
               hi_we    = 1'b1;
               lo_we    = 1'b1;
               hi_wdata = product.half.hi;
               lo_wdata = product.half.lo;
            end
            cpu_defines_pkg::op_mthi: hi_we = 1'b1;
            cpu_defines_pkg::op_mtlo: lo_we = 1'b1;
            cpu_defines_pkg::op_nop:  ;  // nothing to write
            default: ;
         endcase
      end
      if (flush) begin
         hi_we = 1'b0;
         lo_we = 1'b0;
      end
   end

   // a write while the pipeline is held would be lost or doubled
   a_no_write_in_stall: assert property (
      @(posedge clk) disable iff (!rst)
      !(hi_we && stall)
   ) else $error("HI write while stalled");

endmodule

// ==== hdl/hilo_regs.sv ====
/*
 * Architectural HI/LO register pair. Writes land at the clock edge when
 * enabled; MFHI/MFLO read in the same cycle and see a pending write
 * through the forwarding path.
 */
`timescale 1ns/1ns

module hilo_regs (
   input  logic                                       clk,
   input  logic                                       rst,
   input  logic [cpu_defines_pkg::alu_op_width-1:0]   alu_op,
   input  logic                                       hi_we,
   input  logic                                       lo_we,
   input  logic [cpu_defines_pkg::word_width-1:0]     hi_wdata,
   input  logic [cpu_defines_pkg::word_width-1:0]     lo_wdata,
   output logic [cpu_defines_pkg::word_width-1:0]     hilo_rdata,
   output logic [cpu_defines_pkg::word_width-1:0]     hi,
   output logic [cpu_defines_pkg::word_width-1:0]     lo
);

   muldiv_pkg::muldiv_result_u               hilo_q;
   logic [cpu_defines_pkg::word_width-1:0]   hi_fwd;
   logic [cpu_defines_pkg::word_width-1:0]   lo_fwd;

   always_ff @(posedge clk or negedge rst) begin
      if (!rst) begin
         hilo_q.whole <= '0;
      end else begin
         if (hi_we) begin
            hilo_q.half.hi <= hi_wdata;
         end
         if (lo_we) begin
            hilo_q.half.lo <= lo_wdata;
         end
      end
   end

   assign hi = hilo_q.half.hi;
   assign lo = hilo_q.half.lo;

   // same-cycle write wins over the stored value
   assign hi_fwd = hi_we ? hi_wdata : hilo_q.half.hi;
   assign lo_fwd = lo_we ? lo_wdata : hilo_q.half.lo;

   always_comb begin
      case (alu_op)
         cpu_defines_pkg::op_mfhi: hilo_rdata = hi_fwd;
         cpu_defines_pkg::op_mflo: hilo_rdata = lo_fwd;
         default:                  hilo_rdata = '0;
      endcase
   end

endmodule

// ==== hdl/exe_muldiv_top.sv ====
/*
 * Execute-stage multiply/divide top: the control unit, its serial divider
 * and the HI/LO registers, wired together for the pipeline.
 */
`timescale 1ns/1ns

module exe_muldiv_top (
   input  logic                                       clk,
   input  logic                                       rst,
   input  logic [cpu_defines_pkg::alu_op_width-1:0]   alu_op,
   input  logic [cpu_defines_pkg::word_width-1:0]     operand_a,
   input  logic [cpu_defines_pkg::word_width-1:0]     operand_b,
   input  logic                                       flush,
   output logic                                       stall,
   output logic [cpu_defines_pkg::word_width-1:0]     hilo_rdata,
   output logic [cpu_defines_pkg::word_width-1:0]     hi,
   output logic [cpu_defines_pkg::word_width-1:0]     lo
);

   logic                                    div_start;
   logic                                    div_abort;
   logic                                    div_signed;
   logic                                    div_done;
   logic [cpu_defines_pkg::word_width-1:0]  dividend;
   logic [cpu_defines_pkg::word_width-1:0]  divisor;
   muldiv_pkg::muldiv_result_u              div_result;
   logic                                    hi_we;
   logic                                    lo_we;
   logic [cpu_defines_pkg::word_width-1:0]  hi_wdata;
   logic [cpu_defines_pkg::word_width-1:0]  lo_wdata;

   muldiv_unit u_muldiv_unit (
      .clk(clk), .rst(rst), .alu_op(alu_op),
      .operand_a(operand_a), .operand_b(operand_b), .flush(flush),
      .div_done(div_done), .div_result(div_result),
      .div_start(div_start), .div_abort(div_abort), .div_signed(div_signed),
      .dividend(dividend), .divisor(divisor), .stall(stall),
      .hi_we(hi_we), .lo_we(lo_we), .hi_wdata(hi_wdata), .lo_wdata(lo_wdata)
   );

   serial_divider u_serial_divider (
      .clk(clk), .rst(rst), .div_start(div_start), .div_abort(div_abort),
      .div_signed(div_signed), .dividend(dividend), .divisor(divisor),
      .div_done(div_done), .div_result(div_result)
   );

   hilo_regs u_hilo_regs (
      .clk(clk), .rst(rst), .alu_op(alu_op),
      .hi_we(hi_we), .lo_we(lo_we), .hi_wdata(hi_wdata), .lo_wdata(lo_wdata),
      .hilo_rdata(hilo_rdata), .hi(hi), .lo(lo)
   );

endmodule

// ==== dv/tb_exe_muldiv.sv ====
/*
 * Table-driven testbench for the execute-stage multiply/divide block.
 * Each row drives one operation, waits out any stall, then issues a NOP
 * and compares HI, LO, the MFHI/MFLO read data and the stall length.
 */
`timescale 1ns/1ns

module tb_exe_muldiv;

   localparam int half_period  = 20;  // 40 ns clock
   localparam int reset_cycles = 16;
   localparam int rand_seed    = 38014;
   localparam int max_rows     = 32;
   localparam int stall_limit  = 40;  // per-row bound on a held pipeline
   localparam int row_cycles   = 40;  // budget per row for the run timeout

   logic                                       clk;
   logic                                       rst;
   logic [cpu_defines_pkg::alu_op_width-1:0]   alu_op;
   logic [cpu_defines_pkg::word_width-1:0]     operand_a;
   logic [cpu_defines_pkg::word_width-1:0]     operand_b;
   logic                                       flush;
   logic                                       stall;
   logic [cpu_defines_pkg::word_width-1:0]     hilo_rdata;
   logic [cpu_defines_pkg::word_width-1:0]     hi;
   logic [cpu_defines_pkg::word_width-1:0]     lo;

   // stimulus and expected values, one entry per test
   string                                      row_name [max_rows];
   logic [cpu_defines_pkg::alu_op_width-1:0]   row_op [max_rows];
   logic [31:0]                                row_a [max_rows];
   logic [31:0]                                row_b [max_rows];
   int                                         row_flush_at [max_rows];  // -1 means no flush
   logic [31:0]                                row_exp_hi [max_rows];
   logic [31:0]                                row_exp_lo [max_rows];
   logic [31:0]                                row_exp_rdata [max_rows];
   int                                         row_exp_stall [max_rows];

   int          num_rows       = 0;
   int          error_count    = 0;
   int          check_count    = 0;
   int          cycle_count    = 0;
   int          timeout_cycles = 100000;
   logic [31:0] model_hi       = '0;  // reference HI/LO while the table is built
   logic [31:0] model_lo       = '0;

   exe_muldiv_top UUT (
      .clk(clk), .rst(rst), .alu_op(alu_op),
      .operand_a(operand_a), .operand_b(operand_b), .flush(flush),
      .stall(stall), .hilo_rdata(hilo_rdata), .hi(hi), .lo(lo)
   );

   always #half_period clk = ~clk;

   always @(posedge clk) begin
      cycle_count = cycle_count + 1;
      if (cycle_count > timeout_cycles) begin
         $display("timeout: run did not finish within %0d cycles", timeout_cycles);
         $display("Simulation finished: FAIL");
         $finish;
      end
   end

   // 64-bit product, signed or unsigned
   function automatic logic [63:0] product_of(input logic [31:0] a, input logic [31:0] b,
                                              input bit signed_op);
      longint      sa;
      longint      sb;
      logic [63:0] ua;
      logic [63:0] ub;
      sa = longint'($signed(a));
      sb = longint'($signed(b));
      ua = {32'd0, a};
      ub = {32'd0, b};
      if (signed_op) begin
         return 64'(sa * sb);
      end
      return ua * ub;
   endfunction

   // {remainder, quotient}, truncated toward zero
   function automatic logic [63:0] quotient_remainder(input logic [31:0] a,
                                                      input logic [31:0] b,
                                                      input bit signed_op);
      longint sa;
      longint sb;
      longint q;
      longint r;
      if (!signed_op && b == 32'd0) begin
         return {a, 32'hFFFF_FFFF};  // all-ones quotient, dividend left over
      end
      sa = signed_op ? longint'($signed(a)) : longint'({32'd0, a});
      sb = signed_op ? longint'($signed(b)) : longint'({32'd0, b});
      q  = sa / sb;
      r  = sa % sb;
      return {r[31:0], q[31:0]};
   endfunction

   task automatic add_row(input string name, input logic [4:0] op, input logic [31:0] a,
                          input logic [31:0] b, input int flush_at);
      logic [63:0] res;
      int          cycles;
      res    = {model_hi, model_lo};
      cycles = 0;
      case (op)
         cpu_defines_pkg::op_mult:  res = product_of(a, b, 1'b1);
         cpu_defines_pkg::op_multu: res = product_of(a, b, 1'b0);
         cpu_defines_pkg::op_div: begin
            res    = quotient_remainder(a, b, 1'b1);
            cycles = muldiv_pkg::div_iterations;  // done lands in cycle 32
         end
         cpu_defines_pkg::op_divu: begin
            res    = quotient_remainder(a, b, 1'b0);
            cycles = muldiv_pkg::div_iterations;
         end
         cpu_defines_pkg::op_mthi:  res[63:32] = a;
         cpu_defines_pkg::op_mtlo:  res[31:0] = a;
         default: ;
      endcase
      if (flush_at >= 0) begin
         res = {model_hi, model_lo};  // flushed, nothing written
         if (cycles != 0) cycles = flush_at;
      end
      row_name[num_rows]      = name;
      row_op[num_rows]        = op;
      row_a[num_rows]         = a;
      row_b[num_rows]         = b;
      row_flush_at[num_rows]  = flush_at;
      row_exp_stall[num_rows] = cycles;
      row_exp_rdata[num_rows] = (op == cpu_defines_pkg::op_mfhi) ? model_hi :
                                (op == cpu_defines_pkg::op_mflo) ? model_lo : 32'd0;
      model_hi                = res[63:32];
      model_lo                = res[31:0];
      row_exp_hi[num_rows]    = model_hi;
      row_exp_lo[num_rows]    = model_lo;
      num_rows                = num_rows + 1;
   endtask

   task automatic fill_table();
      logic [31:0] ra;
      logic [31:0] rb;
      int          k;
      add_row("mult_small", cpu_defines_pkg::op_mult, 32'd7, 32'd9, -1);
      add_row("mult_neg_pos", cpu_defines_pkg::op_mult, 32'hFFFF_FFFD, 32'd5, -1);
      add_row("mult_neg_neg", cpu_defines_pkg::op_mult, 32'hFFFF_FFFF, 32'hFFFF_FFFF, -1);
      add_row("multu_all_ones", cpu_defines_pkg::op_multu, 32'hFFFF_FFFF, 32'hFFFF_FFFF, -1);
      add_row("multu_random", cpu_defines_pkg::op_multu, $urandom, $urandom, -1);
      add_row("mult_random", cpu_defines_pkg::op_mult, $urandom, $urandom, -1);
      add_row("mfhi_after_mult", cpu_defines_pkg::op_mfhi, 32'd0, 32'd0, -1);
      add_row("mflo_after_mult", cpu_defines_pkg::op_mflo, 32'd0, 32'd0, -1);
      for (k = 0; k < 3; k++) begin
         ra = $urandom;
         rb = (k == 0) ? ($urandom % 1000) + 1 : $urandom;
         if (rb == 32'd0) rb = 32'd1;
         add_row($sformatf("divu_random_%0d", k), cpu_defines_pkg::op_divu, ra, rb, -1);
      end
      for (k = 0; k < 3; k++) begin
         ra = $urandom;
         rb = (k == 0) ? ($urandom % 1000) + 1 : $urandom;
         if (rb == 32'd0) rb = 32'd3;  // signed divide by zero is undefined
         add_row($sformatf("div_random_%0d", k), cpu_defines_pkg::op_div, ra, rb, -1);
      end
      add_row("div_neg_dividend", cpu_defines_pkg::op_div, 32'hFFFF_FFF9, 32'd2, -1);
      add_row("div_neg_divisor", cpu_defines_pkg::op_div, 32'd7, 32'hFFFF_FFFE, -1);
      add_row("div_both_neg", cpu_defines_pkg::op_div, 32'hFFFF_FF9C, 32'hFFFF_FFF9, -1);
      add_row("div_min_by_neg1", cpu_defines_pkg::op_div, 32'h8000_0000, 32'hFFFF_FFFF, -1);
      add_row("divu_by_zero", cpu_defines_pkg::op_divu, 32'h1234_5678, 32'd0, -1);
      add_row("mthi", cpu_defines_pkg::op_mthi, 32'hA5A5_0F0F, 32'd0, -1);
      add_row("mtlo", cpu_defines_pkg::op_mtlo, 32'h3C3C_F0F0, 32'd0, -1);
      add_row("mfhi_after_mthi", cpu_defines_pkg::op_mfhi, 32'd0, 32'd0, -1);
      add_row("mflo_after_mtlo", cpu_defines_pkg::op_mflo, 32'd0, 32'd0, -1);
      add_row("flush_during_div", cpu_defines_pkg::op_div, 32'd1000, 32'd7, 10);
      add_row("flush_with_mult", cpu_defines_pkg::op_mult, 32'd1234, 32'd5678, 0);
      add_row("div_after_flush", cpu_defines_pkg::op_div, 32'hFFFF_3CB0, 32'd123, -1);
   endtask

   task automatic compare(input string what, input logic [31:0] expected,
                          input logic [31:0] actual);
      check_count = check_count + 1;
      if (expected !== actual) begin
         $display("[FAIL] %s expected %h actual %h", what, expected, actual);
         error_count = error_count + 1;
      end
   endtask

   task automatic apply_row(input int i);
      int          waited;
      int          errors_before;
      logic [31:0] rdata_seen;
      errors_before = error_count;
      waited        = 0;
      @(posedge clk);
      #2;
      alu_op    = row_op[i];
      operand_a = row_a[i];
      operand_b = row_b[i];
      flush     = (row_flush_at[i] == 0);
      @(negedge clk);
      while (stall && waited < stall_limit) begin
         @(posedge clk);
         #2;
         waited = waited + 1;
         if (waited == row_flush_at[i]) flush = 1'b1;
         @(negedge clk);
      end
      if (stall) begin
         $display("test %s: stall still high after %0d cycles", row_name[i], stall_limit);
         error_count = error_count + 1;
      end
      rdata_seen = hilo_rdata;  // read data of the op's last cycle
      @(posedge clk);
      #2;
      alu_op    = cpu_defines_pkg::op_nop;
      operand_a = '0;
      operand_b = '0;
      flush     = 1'b0;
      @(negedge clk);
      compare({row_name[i], " stall cycles"}, 32'(row_exp_stall[i]), 32'(waited));
      compare({row_name[i], " hi"}, row_exp_hi[i], hi);
      compare({row_name[i], " lo"}, row_exp_lo[i], lo);
      if (row_op[i] == cpu_defines_pkg::op_mfhi || row_op[i] == cpu_defines_pkg::op_mflo) begin
         compare({row_name[i], " hilo_rdata"}, row_exp_rdata[i], rdata_seen);
      end
      $display("test %0d %s: %s", i, row_name[i], (error_count == errors_before) ? "ok" : "errors");
   endtask

   initial begin
      int i;
      clk       = 1'b0;
      rst       = 1'b0;
      alu_op    = cpu_defines_pkg::op_nop;
      operand_a = '0;
      operand_b = '0;
      flush     = 1'b0;
      void'($urandom(rand_seed));
      fill_table();
      timeout_cycles = num_rows * row_cycles + reset_cycles;
      repeat (reset_cycles) @(posedge clk);
      #2;
      rst = 1'b1;
      for (i = 0; i < num_rows; i++) begin
         apply_row(i);
      end
      $display("tests %0d, checks %0d, errors %0d", num_rows, check_count, error_count);
      if (error_count == 0) begin
         $display("Simulation finished: PASS");
      end else begin
         $display("Simulation finished: FAIL");
      end
      $finish;
   end

endmodule

// ==== src.f ====
hdl/cpu_defines_pkg.sv
hdl/muldiv_pkg.sv
hdl/serial_divider.sv
hdl/muldiv_unit.sv
hdl/hilo_regs.sv
hdl/exe_muldiv_top.sv
dv/tb_exe_muldiv.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the multiply/divide testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir build.log sim.log

verilator --binary --timing --assert -f src.f --top-module tb_exe_muldiv \
   -o sim_exe_muldiv > build.log 2>&1 \
   && ./obj_dir/sim_exe_muldiv > sim.log 2>&1 \
   || { echo "build or run failed, see build.log and sim.log"; exit 1; }

grep -q "Simulation finished: PASS" sim.log \
   && echo "simulation passed" \
   || { echo "simulation failed, see sim.log"; exit 1; }
